/* run.sh */
#!/bin/sh
# Build and run the bus glue testbench with Verilator
verilator --binary --timing --assert -j 0 --top-module s16b_main_tb -f tb.f \
    --Mdir obj_dir -o sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

/* source/s16b_bus_decode.sv */
// ========================================
// Main CPU address decode
// Chip selects and ROM address by board
// ========================================
module s16b_bus_decode
    import s16b_bus_pkg::*;
    import s16b_cab_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  game_id_t  game_id,

    input  cpu_addr_t addr,
    input  logic      asn,
    input  logic      udsn,
    input  logic      ldsn,
    input  logic      rnw,

    output logic      rom_cs,
    output logic      ram_cs,
    output logic      vram_cs,
    output logic      char_cs,
    output logic      objram_cs,
    output logic      pal_cs,
    output logic      io_cs,
    output logic      tbank_cs,
    output rom_addr_t rom_addr,
    output logic      udswn,
    output logic      ldswn
);

    region_t     region;
    region_vec_t active;
    logic [1:0]  act_enc;   // ROM bank 0 to 2
    logic        busn;      // Low once a data strobe is out

    assign udswn  = udsn | rnw;
    assign ldswn  = ldsn | rnw;
    assign busn   = asn | (udsn & ldsn);
    assign region = addr[22:20];
    assign active = 8'd1 << region;

    always_comb begin
        case (active[2:0])
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    // ROM wiring differs between board families
    always_comb begin
        casez (game_id[7:3])
            5'b001??: rom_addr = addr[18:1];            // 171-5797
            5'b0001?: begin
                if (game_id == 8'h10 || game_id == 8'h1a) begin
                    rom_addr = {act_enc, addr[16:1]};   // 171-5358, large ROMs
                end else begin
                    rom_addr = {1'b0, act_enc, addr[15:1]};
                end
            end
            5'b00001: rom_addr = {1'b0, addr[17:1]};    // Korean board
            default:  rom_addr = {act_enc[0], addr[17:1]};  // 171-5521 and 171-5704
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (!asn) begin
            rom_cs    <= (|active[2:0]) && rnw;
            tbank_cs  <= active[2] && !rnw;             // Tile bank latch sits on bank 2
            char_cs   <= active[reg_vram] && addr[16];
            vram_cs   <= !busn && active[reg_vram] && !addr[16];
            ram_cs    <= !busn && active[reg_ram];
            objram_cs <= active[reg_oram];
            pal_cs    <= active[reg_pal];
            io_cs     <= active[reg_io];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end
    end

endmodule

/* source/s16b_bus_pkg.sv */
// ========================================
// System 16B main CPU bus definitions
// Widths, region map and CPU clock ratio
// ========================================
package s16b_bus_pkg;

    // 68000 bus as seen by the glue
    typedef logic [23:1] cpu_addr_t;    // Word address
    typedef logic [15:0] cpu_data_t;
    typedef logic [18:1] rom_addr_t;    // 512 kB of program ROM

    // Region decode on address bits 22:20
    typedef logic [2:0] region_t;
    typedef logic [7:0] region_vec_t;   // One-hot active region

    // Regions 0 to 2 are program ROM banks
    localparam region_t reg_ram  = 3'd3;    // Work RAM
    localparam region_t reg_oram = 3'd4;    // Object RAM
    localparam region_t reg_vram = 3'd5;    // Tile and text RAM
    localparam region_t reg_pal  = 3'd6;    // Colour RAM
    localparam region_t reg_io   = 3'd7;

    // CPU clock enable is cen_num/cen_den of clk
    localparam logic [7:0] cen_num = 8'd29;
    localparam logic [7:0] cen_den = 8'd146;

    // Value seen on an undriven data bus
    localparam cpu_data_t data_idle = 16'hffff;

endpackage

/* source/s16b_bus_resp.sv */
// ========================================
// CPU bus response
// Clock enable, read data mux and DTACK
// ========================================
module s16b_bus_resp
    import s16b_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      asn,

    input  logic      rom_cs,
    input  logic      ram_cs,
    input  logic      vram_cs,
    input  logic      char_cs,
    input  logic      objram_cs,
    input  logic      pal_cs,
    input  logic      io_cs,

    input  logic      rom_ok,
    input  logic      ram_ok,
    input  cpu_data_t rom_data,
    input  cpu_data_t ram_data,     // Shared by work RAM and VRAM
    input  cpu_data_t char_dout,
    input  cpu_data_t pal_dout,
    input  cpu_data_t obj_dout,
    input  logic [7:0] cab_dout,

    output cpu_data_t cpu_din,
    output logic      dtackn,
    output logic      cpu_cen
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_acked
    } dtack_state_t;

    dtack_state_t state;
    logic [7:0]   cen_acc;
    logic [8:0]   cen_sum;
    logic [8:0]   cen_wrap;
    logic         asn_q;
    logic         busy;

    // Fractional enable, 29 pulses every 146 clocks
    assign cen_sum  = {1'b0, cen_acc} + {1'b0, cen_num};
    assign cen_wrap = cen_sum - {1'b0, cen_den};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_acc <= 8'd0;
            cpu_cen <= 1'b0;
        end else if (cen_sum >= {1'b0, cen_den}) begin
            cen_acc <= cen_wrap[7:0];
            cpu_cen <= 1'b1;
        end else begin
            cen_acc <= cen_sum[7:0];
            cpu_cen <= 1'b0;
        end
    end

    // Unmapped addresses keep the last value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= data_idle;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {data_idle[15:8], cab_dout};
        end
    end

    assign busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    // Wait state starts on the second edge of the cycle
    // so chip selects and I/O data have settled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            asn_q <= 1'b1;
        end else begin
            asn_q <= asn;
            case (state)
                st_idle: if (!asn && !asn_q) state <= st_wait;
                st_wait: begin
                    if (asn) begin
                        state <= st_idle;   // Cycle aborted
                    end else if (cpu_cen && !busy) begin
                        state <= st_acked;
                    end
                end
                st_acked: if (asn) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    assign dtackn = state != st_acked;

endmodule

/* source/s16b_cab_pkg.sv */
// ========================================
// Cabinet and game definitions
// Game ids, I/O pages and input types
// ========================================
package s16b_cab_pkg;

    typedef logic [7:0]  game_id_t;
    typedef logic [7:0]  joy_t;         // Digital joystick, active low
    typedef logic [15:0] ana_t;         // Analog axis, upper byte only
    typedef logic [7:0]  cab_byte_t;    // I/O read byte

    // Games with their own custom input page
    localparam game_id_t game_passsht = 8'h13;
    localparam game_id_t game_sdi     = 8'h12;
    localparam game_id_t game_defense = 8'h19;

    // I/O page number comes from address bits 13:12
    localparam logic [1:0] io_page_ctrl   = 2'd0;   // Video control writes
    localparam logic [1:0] io_page_cab    = 2'd1;   // Coins, starts, joysticks
    localparam logic [1:0] io_page_dip    = 2'd2;
    localparam logic [1:0] io_page_custom = 2'd3;   // Per-game extra inputs

endpackage

/* source/s16b_main.sv */
// ========================================
// System 16B main bus glue, top level
// ========================================
module s16b_main
    import s16b_bus_pkg::*;
    import s16b_cab_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  game_id_t   game_id,

    // 68000 bus
    input  cpu_addr_t  addr,
    input  logic       asn,
    input  logic       udsn,
    input  logic       ldsn,
    input  logic       rnw,
    input  cpu_data_t  cpu_dout,
    output cpu_data_t  cpu_din,
    output logic       dtackn,
    output logic       cpu_cen,

    // Memories
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  cpu_data_t  rom_data,
    input  logic       rom_ok,
    output logic       ram_cs,
    output logic       vram_cs,
    input  cpu_data_t  ram_data,
    input  logic       ram_ok,
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    input  cpu_data_t  char_dout,
    input  cpu_data_t  pal_dout,
    input  cpu_data_t  obj_dout,

    // Video control
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank,

    // Cabinet
    input  joy_t       joystick1,
    input  joy_t       joystick2,
    input  joy_t       joystick3,
    input  joy_t       joystick4,
    input  ana_t       joyana1,
    input  ana_t       joyana2,
    input  ana_t       joyana3,
    input  ana_t       joyana4,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b
);

    logic      io_cs;
    logic      tbank_cs;
    logic      ldswn;
    cab_byte_t cab_dout;

    s16b_bus_decode i_bus_decode (
        .udswn (),      // Upper byte writes only reach external RAM
        .*
    );

    s16b_sys_regs i_sys_regs (.*);

    s16b_bus_resp i_bus_resp (.*);

endmodule

/* source/s16b_sys_regs.sv */
// ========================================
// System registers
// Cabinet inputs and video control writes
// ========================================
module s16b_sys_regs
    import s16b_bus_pkg::*;
    import s16b_cab_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  game_id_t   game_id,

    input  cpu_addr_t  addr,
    input  cpu_data_t  cpu_dout,
    input  logic       ldswn,
    input  logic       io_cs,
    input  logic       tbank_cs,

    input  joy_t       joystick1,
    input  joy_t       joystick2,
    input  joy_t       joystick3,
    input  joy_t       joystick4,
    input  ana_t       joyana1,
    input  ana_t       joyana2,
    input  ana_t       joyana3,
    input  ana_t       joyana4,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,

    output cab_byte_t  cab_dout,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    // Joystick bit order on the cabinet page
    function automatic cab_byte_t sort_joy(input joy_t joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    // Passing Shot wires four players differently
    function automatic cab_byte_t pass_joy(input joy_t joy);
        return {joy[7:4], joy[1:0], joy[3:2]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
            flip     <= 1'b0;
            video_en <= 1'b1;
        end else begin
            cab_dout <= 8'hff;  // Unmapped reads float high
            if (io_cs) begin
                case (addr[13:12])
                    io_page_ctrl: begin
                        if (!ldswn) begin
                            flip     <= cpu_dout[6];
                            video_en <= cpu_dout[5];
                        end
                    end
                    io_page_cab: begin
                        case (addr[2:1])
                            2'd0: cab_dout <= {2'b11, start_button, service, dip_test,
                                               coin_input};
                            2'd1: cab_dout <= sort_joy(joystick1);
                            2'd3: cab_dout <= sort_joy(joystick2);
                            default: cab_dout <= 8'hff;
                        endcase
                    end
                    io_page_dip: cab_dout <= addr[1] ? dipsw_a : dipsw_b;
                    io_page_custom: begin
                        if (addr[9:8] == 2'b10) begin
                            if (game_id == game_passsht) begin
                                case (addr[2:1])
                                    2'd0: cab_dout <= pass_joy(joystick1);
                                    2'd1: cab_dout <= pass_joy(joystick2);
                                    2'd2: cab_dout <= pass_joy(joystick3);
                                    2'd3: cab_dout <= pass_joy(joystick4);
                                endcase
                            end else if (game_id == game_sdi || game_id == game_defense) begin
                                case (addr[2:1])    // Two axes per player
                                    2'd0: cab_dout <= joyana1[15:8];
                                    2'd1: cab_dout <= joyana2[15:8];
                                    2'd2: cab_dout <= joyana3[15:8];
                                    2'd3: cab_dout <= joyana4[15:8];
                                endcase
                            end
                        end
                    end
                endcase
            end
        end
    end

    // Tile bank halves written through ROM bank 2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_cs && !ldswn) begin
            if (addr[1]) begin
                tile_bank[5:3] <= cpu_dout[2:0];
            end else begin
                tile_bank[2:0] <= cpu_dout[2:0];
            end
        end
    end

endmodule

/* tb.f */
source/s16b_bus_pkg.sv
source/s16b_cab_pkg.sv
source/s16b_bus_decode.sv
source/s16b_sys_regs.sv
source/s16b_bus_resp.sv
source/s16b_main.sv
verification/s16b_main_chk.sv
verification/s16b_main_tb.sv

/* verification/s16b_main_chk.sv */
// ========================================
// Bus protocol assertions for the glue
// Chip select exclusion and DTACK timing
// ========================================
module s16b_main_chk (
    input logic clk,
    input logic rst,
    input logic asn,
    input logic dtackn,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic objram_cs,
    input logic pal_cs,
    input logic io_cs,
    input logic tbank_cs
);

    logic [7:0] cs_vec;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, tbank_cs};

    cs_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_vec))
        else $error("Several chip selects active at once");

    // DTACK only inside a cycle
    dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $fell(dtackn) |-> !$past(asn))
        else $error("DTACK asserted with the address strobe high");

    cs_release: assert property (@(posedge clk) disable iff (rst)
        $rose(asn) |=> (cs_vec == 8'd0))
        else $error("Chip select still active after the address strobe rose");

endmodule

bind s16b_main s16b_main_chk i_main_chk (
    .clk       (clk),
    .rst       (rst),
    .asn       (asn),
    .dtackn    (dtackn),
    .rom_cs    (rom_cs),
    .ram_cs    (ram_cs),
    .vram_cs   (vram_cs),
    .char_cs   (char_cs),
    .objram_cs (objram_cs),
    .pal_cs    (pal_cs),
    .io_cs     (io_cs),
    .tbank_cs  (tbank_cs)
);

/* verification/s16b_main_tb.sv */
// ========================================
// Testbench for the System 16B bus glue
// CPU bus model, memory models and checks
// ========================================
module s16b_main_tb
    import s16b_bus_pkg::*;
    import s16b_cab_pkg::*;
();

    localparam cpu_data_t char_tag = 16'hc4a7;
    localparam cpu_data_t pal_tag  = 16'hba1e;
    localparam cpu_data_t obj_tag  = 16'h0b1e;
    localparam region_t  read_regions [5] = '{3'd3, 3'd4, 3'd5, 3'd5, 3'd6};
    localparam game_id_t rom_games [5] = '{8'h2a, 8'h10, 8'h15, 8'h0b, 8'h40};
    localparam game_id_t cab_games [4] = '{8'h13, 8'h12, 8'h19, 8'h20};

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    game_id_t   game_id;
    cpu_addr_t  addr;
    logic       asn, udsn, ldsn, rnw;
    cpu_data_t  cpu_dout, cpu_din;
    logic       dtackn, cpu_cen;
    logic       rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    rom_addr_t  rom_addr;
    cpu_data_t  rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic       rom_ok = 1'b0;
    logic       ram_ok = 1'b0;
    logic       flip, video_en;
    logic [5:0] tile_bank;
    joy_t       joystick1, joystick2, joystick3, joystick4;
    ana_t       joyana1, joyana2, joyana3, joyana4;
    logic [1:0] start_button, coin_input;
    logic       service, dip_test;
    logic [7:0] dipsw_a, dipsw_b;

    int         rom_wait, ram_wait;
    int         issued, clk_count, cen_count;
    int         checks, errors, proto_errors;
    logic [5:0] cs_seen;    // {rom, ram, vram, char, obj, pal} at DTACK
    cpu_data_t  got_q[$];
    cpu_data_t  exp_q[$];
    string      name_q[$];
    string      cmp_name;
    cpu_data_t  cmp_got, cmp_exp;

    s16b_main i_s16b_main (.*);

    initial forever #2 clk = ~clk;

    // Memory models, data is a function of the address
    assign rom_data  = ~rom_addr[16:1];
    assign ram_data  = addr[16:1];
    assign char_dout = char_tag;
    assign pal_dout  = pal_tag;
    assign obj_dout  = obj_tag;

    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = $urandom % 7;    // Next access latency
        end else if (rom_wait == 0) begin
            rom_ok = 1'b1;
        end else begin
            rom_wait = rom_wait - 1;
        end
    end

    always @(negedge clk) begin
        if (!(ram_cs || vram_cs)) begin
            ram_ok   = 1'b0;
            ram_wait = $urandom % 7;
        end else if (ram_wait == 0) begin
            ram_ok = 1'b1;
        end else begin
            ram_wait = ram_wait - 1;
        end
    end

    function automatic cab_byte_t sorted_joy(input joy_t j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    // ROM word address for a CPU address under a given board
    function automatic rom_addr_t board_rom_addr(input cpu_addr_t a, input game_id_t g);
        logic [1:0] bank;
        rom_addr_t  ra;
        bank = a[21:20];
        if (g[7:5] == 3'b001) ra = a[18:1];
        else if (g == 8'h10 || g == 8'h1a) ra = {bank, a[16:1]};
        else if (g[7:4] == 4'b0001) ra = {1'b0, bank, a[15:1]};
        else if (g[7:3] == 5'b00001) ra = {1'b0, a[17:1]};
        else ra = {bank[0], a[17:1]};
        return ra;
    endfunction

    // Expected read data for an address under a given game
    function automatic cpu_data_t ref_read(input cpu_addr_t a, input game_id_t g);
        rom_addr_t  ra;
        cab_byte_t  cab;
        joy_t       pj;
        ra  = board_rom_addr(a, g);
        cab = 8'hff;
        if (a[13:12] == io_page_cab) begin
            if (a[2:1] == 2'd0) cab = {2'b11, start_button, service, dip_test, coin_input};
            if (a[2:1] == 2'd1) cab = sorted_joy(joystick1);
            if (a[2:1] == 2'd3) cab = sorted_joy(joystick2);
        end else if (a[13:12] == io_page_dip) begin
            cab = a[1] ? dipsw_a : dipsw_b;
        end else if (a[13:12] == io_page_custom && a[9:8] == 2'd2) begin
            pj = a[2] ? (a[1] ? joystick4 : joystick3) : (a[1] ? joystick2 : joystick1);
            if (g == game_passsht) cab = {pj[7:4], pj[1:0], pj[3:2]};
            if (g == game_sdi || g == game_defense) begin
                cab = a[2] ? (a[1] ? joyana4[15:8] : joyana3[15:8])
                           : (a[1] ? joyana2[15:8] : joyana1[15:8]);
            end
        end
        case (a[22:20])
            reg_ram:  return a[16:1];
            reg_oram: return obj_tag;
            reg_vram: return a[16] ? char_tag : a[16:1];
            reg_pal:  return pal_tag;
            reg_io:   return {8'hff, cab};
            default:  return ~ra[16:1];
        endcase
    endfunction

    // External chip select expected for a read, same order as cs_seen
    function automatic logic [5:0] read_selects(input cpu_addr_t a);
        case (a[22:20])
            reg_ram:  return 6'b010000;
            reg_oram: return 6'b000010;
            reg_vram: return a[16] ? 6'b000100 : 6'b001000;
            reg_pal:  return 6'b000001;
            reg_io:   return 6'b000000;
            default:  return 6'b100000;
        endcase
    endfunction

    function automatic cpu_addr_t io_addr(input logic [1:0] page, input logic [1:0] sel,
                                          input logic [1:0] word);
        cpu_addr_t a;
        a        = '0;
        a[22:20] = reg_io;
        a[13:12] = page;
        a[9:8]   = sel;
        a[2:1]   = word;
        return a;
    endfunction

    task automatic queue_result(input string nm, input cpu_data_t got, input cpu_data_t exp);
        name_q.push_back(nm);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // One 68000 bus cycle, ended by DTACK
    task automatic bus_cycle(input cpu_addr_t a, input logic rd, input cpu_data_t wdata,
                             output cpu_data_t rdata);
        @(negedge clk);
        addr     = a;
        rnw      = rd;
        cpu_dout = wdata;
        udsn     = 1'b0;
        ldsn     = 1'b0;
        asn      = 1'b0;
        issued++;
        do @(negedge clk); while (dtackn);
        rdata   = cpu_din;
        cs_seen = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs};
        asn     = 1'b1;
        udsn    = 1'b1;
        ldsn    = 1'b1;
        rnw     = 1'b1;
        do @(negedge clk); while (!dtackn);
    endtask

    task automatic read_check(input cpu_addr_t a, input string nm);
        cpu_data_t exp;
        cpu_data_t got;
        exp = ref_read(a, game_id);
        bus_cycle(a, 1'b1, 16'h0000, got);
        queue_result(nm, got, exp);
        queue_result("chip selects", {10'd0, cs_seen}, {10'd0, read_selects(a)});
    endtask

    task automatic randomize_cabinet();
        joystick1    = 8'($urandom);
        joystick2    = 8'($urandom);
        joystick3    = 8'($urandom);
        joystick4    = 8'($urandom);
        joyana1      = 16'($urandom);
        joyana2      = 16'($urandom);
        joyana3      = 16'($urandom);
        joyana4      = 16'($urandom);
        start_button = 2'($urandom);
        coin_input   = 2'($urandom);
        service      = 1'($urandom);
        dip_test     = 1'($urandom);
        dipsw_a      = 8'($urandom);
        dipsw_b      = 8'($urandom);
    endtask

    always @(negedge clk) begin
        while (got_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            checks++;
            if (cmp_got !== cmp_exp) begin
                errors++;
                $display("** Error at %0t: %s = %h, expected %h", $time, cmp_name,
                         cmp_got, cmp_exp);
            end
        end
    end

    // Bus protocol as seen from the CPU side
    always @(negedge clk) begin
        if (!rst && !dtackn && ((rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok))) begin
            proto_errors++;
            $display("** Error at %0t: DTACK given before the memory was ready", $time);
        end
        if (!$onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs})) begin
            proto_errors++;
            $display("** Error at %0t: more than one chip select active", $time);
        end
    end

    initial begin
        while (clk_count <= 200 * (issued + 1) + 2000) begin
            @(negedge clk);
            clk_count++;
        end
        $display("Watchdog timeout: a bus cycle never completed, %0d bus cycles issued",
                 issued);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        cpu_addr_t  a;
        cpu_data_t  d;
        cpu_data_t  got;
        rom_addr_t  exp_ra;
        logic [5:0] exp_tile;
        void'($urandom(97));
        game_id  = 8'h00;
        addr     = '0;
        asn      = 1'b1;
        udsn     = 1'b1;
        ldsn     = 1'b1;
        rnw      = 1'b1;
        cpu_dout = '0;
        randomize_cabinet();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        queue_result("flip", {15'd0, flip}, 16'd0);
        queue_result("video_en", {15'd0, video_en}, 16'd1);
        queue_result("tile_bank", {10'd0, tile_bank}, 16'd0);
        queue_result("cpu_din", cpu_din, 16'hffff);

        for (int i = 0; i < 20; i++) begin      // RAM, VRAM, char, pal, obj
            a        = cpu_addr_t'($urandom);
            a[23]    = 1'b0;
            a[22:20] = read_regions[i % 5];
            if (a[22:20] == reg_vram) a[16] = (i % 5 == 3);
            read_check(a, "cpu_din");
        end

        for (int k = 0; k < 5; k++) begin       // ROM address by board
            game_id = rom_games[k];
            for (int b = 0; b < 9; b++) begin
                a        = cpu_addr_t'($urandom);
                a[23]    = 1'b0;
                a[22:20] = 3'(b % 3);
                read_check(a, "cpu_din");
                exp_ra = board_rom_addr(a, game_id);
                queue_result("rom_addr[18:17]", {14'd0, rom_addr[18:17]},
                             {14'd0, exp_ra[18:17]});
            end
        end

        for (int k = 0; k < 4; k++) begin
            game_id = cab_games[k];
            randomize_cabinet();
            for (int w = 0; w < 4; w++) begin
                read_check(io_addr(io_page_cab, 2'd0, 2'(w)), "cpu_din");
                read_check(io_addr(io_page_custom, 2'd2, 2'(w)), "cpu_din");
                read_check(io_addr(io_page_custom, 2'd1, 2'(w)), "cpu_din");
            end
            read_check(io_addr(io_page_dip, 2'd0, 2'd0), "cpu_din");
            read_check(io_addr(io_page_dip, 2'd0, 2'd1), "cpu_din");
            read_check(io_addr(io_page_ctrl, 2'd0, 2'd0), "cpu_din");
        end

        exp_tile = 6'd0;
        for (int i = 0; i < 8; i++) begin       // Video control writes
            d = 16'($urandom);
            bus_cycle(io_addr(io_page_ctrl, 2'd0, 2'd0), 1'b0, d, got);
            queue_result("flip", {15'd0, flip}, {15'd0, d[6]});
            queue_result("video_en", {15'd0, video_en}, {15'd0, d[5]});
            a        = cpu_addr_t'($urandom);
            a[23]    = 1'b0;
            a[22:20] = 3'd2;
            bus_cycle(a, 1'b0, d, got);
            if (a[1]) exp_tile[5:3] = d[2:0];
            else exp_tile[2:0] = d[2:0];
            queue_result("tile_bank", {10'd0, tile_bank}, {10'd0, exp_tile});
        end

        cen_count = 0;
        repeat (1460) begin
            @(negedge clk);
            if (cpu_cen) cen_count++;
        end
        queue_result("cpu_cen pulses", 16'(cen_count), 16'd290);

        repeat (2) @(negedge clk);
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d, bus cycles: %0d",
                 checks, errors, proto_errors, issued);
        if (errors == 0 && proto_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
